// ==== hdl/eth_pkg.sv ====
`default_nettype none

package eth_pkg;

	// ------------------------------
	// sizes and frame constants
	// ------------------------------
	localparam int RING_DEPTH = 8;              // packet slots per ring

	typedef logic [7:0]                    byte_t;
	typedef logic [8:0]                    plen_t;   // byte address or packet length
	typedef logic [$clog2(RING_DEPTH)-1:0] slot_t;
	typedef logic [15:0]                   result_t;

	localparam plen_t       MAX_LEN       = 9'd402;
	localparam plen_t       PREAMBLE_LEN  = 9'd7;
	localparam byte_t       PREAMBLE_BYTE = 8'h55;
	localparam byte_t       SFD_BYTE      = 8'hD5;
	localparam plen_t       FCS_LEN       = 9'd4;
	localparam plen_t       IFG_LEN       = 9'd12;     // idle cycles between frames
	localparam logic [31:0] CRC_RESIDUE   = 32'hC704DD7B;

	// ------------------------------
	// host and ring ports
	// ------------------------------
	typedef enum logic [2:0] {
		OP_READ,
		OP_READ_LEN,
		OP_READ_NEXT,
		OP_WRITE,
		OP_WRITE_LEN,
		OP_WRITE_NEXT
	} host_op_t;

	typedef struct packed {
		host_op_t op;
		plen_t    addr;
		byte_t    data;
	} host_req_t;

	// on commit the addr field carries the packet length
	typedef struct packed {
		logic  en;
		plen_t addr;
		byte_t data;
		logic  commit;
		logic  abort;
	} ring_wr_t;

	typedef struct packed {
		logic  valid;      // oldest packet is ready
		plen_t len;
	} ring_stat_t;

	typedef struct packed {
		logic  en;
		byte_t data;
	} gmii_tx_t;

	typedef struct packed {
		logic  dv;
		logic  er;
		byte_t data;
	} gmii_rx_t;

	// CRC-32 over one byte, bit 0 goes out first on the wire
	function automatic logic [31:0] next_crc32_d8(input byte_t data, input logic [31:0] crc);
		logic [31:0] c;
		logic        fb;
		c = crc;
		for (int i = 0; i < 8; i++) begin
			fb = c[31] ^ data[i];
			c  = {c[30:0], 1'b0} ^ ({32{fb}} & 32'h04C1_1DB7);
		end
		return c;
	endfunction

	function automatic byte_t reverse_byte(input byte_t data);
		byte_t r;
		for (int i = 0; i < 8; i++)
			r[i] = data[7 - i];
		return r;
	endfunction

endpackage

`default_nettype wire

// ==== hdl/packet_ring.sv ====
`timescale 1ns/100ps
`default_nettype none

module packet_ring import eth_pkg::*; (
	input  wire             clock,
	input  wire             reset,
	input  wire ring_wr_t   wr_i,        // writer fills the tail slot
	output ring_stat_t      stat_o,
	output logic            full_o,
	input  wire plen_t      rd_addr_i,   // reader works on the head slot
	output byte_t           rd_data_o,
	input  wire             release_i
);

	typedef logic [$clog2(RING_DEPTH):0] cnt_t;

	byte_t mem [RING_DEPTH][MAX_LEN];    // byte storage per slot
	plen_t len_mem [RING_DEPTH];
	slot_t head_q;
	slot_t tail_q;
	cnt_t  count_q;                      // committed packets held

	function automatic slot_t next_slot(input slot_t s);
		return (s == slot_t'(RING_DEPTH - 1)) ? '0 : s + slot_t'(1);
	endfunction

	assign full_o       = (count_q == cnt_t'(RING_DEPTH));
	assign stat_o.valid = (count_q != '0);
	assign stat_o.len   = len_mem[head_q];

	// ------------------------------
	// storage
	// ------------------------------
	always_ff @(posedge clock) begin
		if (wr_i.en)
			mem[tail_q][wr_i.addr] <= wr_i.data;
		if (wr_i.commit)
			len_mem[tail_q] <= wr_i.addr;    // close slot with its length
		else if (wr_i.abort)
			len_mem[tail_q] <= '0;           // drop partial slot
		rd_data_o <= mem[head_q][rd_addr_i]; // registered read
	end

	// ------------------------------
	// slot pointers
	// ------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
		end else begin
			if (wr_i.commit)
				tail_q <= next_slot(tail_q);
			if (release_i)
				head_q <= next_slot(head_q);
			case ({wr_i.commit, release_i})
				2'b10:   count_q <= count_q + cnt_t'(1);
				2'b01:   count_q <= count_q - cnt_t'(1);
				default: ;                   // both or neither
			endcase
		end
	end

	// the writer checks full_o before it closes a slot
	a_commit_not_full: assert property (@(posedge clock) disable iff (reset)
		wr_i.commit |-> !full_o);

	// the reader only releases a packet it was shown
	a_release_not_empty: assert property (@(posedge clock) disable iff (reset)
		release_i |-> stat_o.valid);

	a_addr_in_slot: assert property (@(posedge clock) disable iff (reset)
		wr_i.en |-> (wr_i.addr < MAX_LEN));

endmodule

`default_nettype wire

// ==== hdl/host_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module host_port import eth_pkg::*; (
	input  wire             clock,
	input  wire             reset,
	input  wire             start_i,
	input  wire host_req_t  req_i,
	output logic            done_o,
	output result_t         result_o,
	output ring_wr_t        tx_wr_o,
	input  wire             tx_full_i,
	input  wire ring_stat_t rx_stat_i,
	output plen_t           rx_rd_addr_o,
	input  wire byte_t      rx_rd_data_i,
	output logic            rx_release_o
);

	plen_t    pend_len_q;      // length of the packet being written
	plen_t    pend_len_d;
	plen_t    next_len;
	logic     wr_ok;
	result_t  res_d;
	result_t  res_q;
	host_op_t op_q;
	logic     rd_ok_q;         // read address inside the held packet

	assign next_len     = req_i.addr + plen_t'(1);
	assign wr_ok        = (req_i.addr < MAX_LEN) && !tx_full_i;
	assign rx_rd_addr_o = req_i.addr;

	// ------------------------------
	// operation decode
	// ------------------------------
	always_comb begin
		tx_wr_o      = '0;
		tx_wr_o.addr = req_i.addr;
		tx_wr_o.data = req_i.data;
		rx_release_o = 1'b0;
		pend_len_d   = pend_len_q;
		res_d        = '0;
		if (start_i) begin
			case (req_i.op)
				OP_READ_LEN:
					res_d = rx_stat_i.valid ? result_t'(rx_stat_i.len) : '0;
				OP_READ_NEXT: begin
					rx_release_o = rx_stat_i.valid;
					res_d        = result_t'(!rx_stat_i.valid);  // 1 when nothing held
				end
				OP_WRITE: begin
					tx_wr_o.en = wr_ok;
					res_d      = result_t'(!wr_ok);
					if (wr_ok && (next_len > pend_len_q))
						pend_len_d = next_len;
				end
				OP_WRITE_LEN:
					res_d = result_t'(pend_len_q);
				OP_WRITE_NEXT: begin
					if (tx_full_i) begin
						res_d = result_t'(1);
					end else if (pend_len_q != '0) begin
						tx_wr_o.commit = 1'b1;
						tx_wr_o.addr   = pend_len_q;   // length rides on addr
						pend_len_d     = '0;
					end
				end
				default: ;                         // read data arrives next cycle
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			done_o     <= 1'b0;
			pend_len_q <= '0;
		end else begin
			done_o     <= start_i;
			pend_len_q <= pend_len_d;
		end
	end

	always_ff @(posedge clock) begin
		if (start_i) begin
			op_q    <= req_i.op;
			res_q   <= res_d;
			rd_ok_q <= rx_stat_i.valid && (req_i.addr < rx_stat_i.len);
		end
	end

	// ring read is registered, so the byte is picked up here
	assign result_o = (op_q == OP_READ) ? (rd_ok_q ? result_t'(rx_rd_data_i) : '0) : res_q;

	// host keeps one operation in flight
	a_done_single: assert property (@(posedge clock) disable iff (reset)
		done_o |=> !done_o);

endmodule

`default_nettype wire

// ==== hdl/gmii_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module gmii_tx import eth_pkg::*; (
	input  wire             clock,
	input  wire             reset,
	input  wire ring_stat_t stat_i,
	output plen_t           rd_addr_o,
	input  wire byte_t      rd_data_i,
	output logic            release_o,
	output gmii_tx_t        tx_o
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_PRE,
		ST_SFD,
		ST_DATA,
		ST_FCS,
		ST_GAP
	} tx_state_t;

	tx_state_t   state_q;     // phase now on the wire
	plen_t       cnt_q;       // preamble, data, fcs and gap count
	plen_t       len_q;
	plen_t       addr_q;      // two bytes ahead of the wire
	logic [31:0] crc_q;
	logic        last_pre;

	assign last_pre  = (state_q == ST_PRE) && (cnt_q == PREAMBLE_LEN);
	assign rd_addr_o = addr_q;
	assign release_o = (state_q == ST_GAP) && (cnt_q == IFG_LEN);

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= ST_IDLE;
			tx_o.en <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					addr_q <= '0;
					crc_q  <= '1;
					if (stat_i.valid) begin
						state_q   <= ST_PRE;
						len_q     <= stat_i.len;
						cnt_q     <= plen_t'(1);
						tx_o.en   <= 1'b1;
						tx_o.data <= PREAMBLE_BYTE;
					end
				end
				ST_PRE: begin
					if (last_pre) begin
						state_q   <= ST_SFD;
						tx_o.data <= SFD_BYTE;
						addr_q    <= addr_q + plen_t'(1);
					end else begin
						cnt_q <= cnt_q + plen_t'(1);
					end
				end
				ST_SFD: begin
					state_q   <= ST_DATA;
					tx_o.data <= rd_data_i;           // byte 0
					crc_q     <= next_crc32_d8(rd_data_i, crc_q);
					cnt_q     <= plen_t'(1);
					addr_q    <= addr_q + plen_t'(1);
				end
				ST_DATA: begin
					if (cnt_q == len_q) begin
						state_q   <= ST_FCS;
						tx_o.data <= ~reverse_byte(crc_q[31:24]);
						crc_q     <= {crc_q[23:0], 8'h00};
						cnt_q     <= plen_t'(1);
					end else begin
						tx_o.data <= rd_data_i;
						crc_q     <= next_crc32_d8(rd_data_i, crc_q);
						cnt_q     <= cnt_q + plen_t'(1);
						addr_q    <= addr_q + plen_t'(1);
					end
				end
				ST_FCS: begin
					if (cnt_q == FCS_LEN) begin
						state_q <= ST_GAP;
						tx_o.en <= 1'b0;
						cnt_q   <= plen_t'(1);
					end else begin
						tx_o.data <= ~reverse_byte(crc_q[31:24]);  // high byte first
						crc_q     <= {crc_q[23:0], 8'h00};
						cnt_q     <= cnt_q + plen_t'(1);
					end
				end
				ST_GAP: begin
					if (release_o)
						state_q <= ST_IDLE;               // slot freed on this edge
					else
						cnt_q <= cnt_q + plen_t'(1);
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// no hole in tx_en between the SFD and the last FCS byte
	a_en_held: assert property (@(posedge clock) disable iff (reset)
		((state_q inside {ST_SFD, ST_DATA, ST_FCS}) && !(state_q == ST_FCS && cnt_q == FCS_LEN))
		|=> tx_o.en);

endmodule

`default_nettype wire

// ==== hdl/gmii_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module gmii_rx import eth_pkg::*; (
	input  wire           clock,
	input  wire           reset,
	input  wire gmii_rx_t rx_i,
	output ring_wr_t      wr_o,
	input  wire           full_i
);

	typedef enum logic [2:0] {
		ST_HUNT,
		ST_PRE,
		ST_SFD,
		ST_DATA,
		ST_DROP
	} rx_state_t;

	rx_state_t   state_q;
	plen_t       cnt_q;       // preamble bytes, then frame bytes
	logic [31:0] crc_q;
	logic        err_q;       // rx_er seen inside the frame
	logic        frame_end;
	logic        frame_ok;
	logic        too_long;

	// ------------------------------
	// frame end checks
	// ------------------------------
	assign frame_end = (state_q == ST_DATA) && !rx_i.dv;
	assign too_long  = (state_q == ST_DATA) && rx_i.dv && (cnt_q == MAX_LEN + FCS_LEN);
	assign frame_ok  = !err_q && (crc_q == CRC_RESIDUE)
		&& (cnt_q >= FCS_LEN + plen_t'(1)) && (cnt_q <= MAX_LEN + FCS_LEN);

	always_comb begin
		wr_o        = '0;
		wr_o.data   = rx_i.data;
		wr_o.addr   = frame_end ? cnt_q - FCS_LEN : cnt_q;   // length at commit
		wr_o.en     = (state_q == ST_DATA) && rx_i.dv && (cnt_q < MAX_LEN);
		wr_o.commit = frame_end && frame_ok;
		wr_o.abort  = (frame_end && !frame_ok) || too_long;
	end

	// ------------------------------
	// receive FSM
	// ------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= ST_HUNT;
		end else begin
			case (state_q)
				ST_HUNT: begin
					if (rx_i.dv) begin
						cnt_q <= plen_t'(1);
						if (rx_i.data == PREAMBLE_BYTE && !rx_i.er)
							state_q <= ST_PRE;
						else
							state_q <= ST_DROP;
					end
				end
				ST_PRE: begin
					if (!rx_i.dv)
						state_q <= ST_HUNT;
					else if (rx_i.data != PREAMBLE_BYTE || rx_i.er)
						state_q <= ST_DROP;
					else if (cnt_q == PREAMBLE_LEN - plen_t'(1))
						state_q <= ST_SFD;            // seventh preamble byte
					else
						cnt_q <= cnt_q + plen_t'(1);
				end
				ST_SFD: begin
					if (!rx_i.dv) begin
						state_q <= ST_HUNT;
					end else if (rx_i.data == SFD_BYTE && !rx_i.er && !full_i) begin
						state_q <= ST_DATA;
						cnt_q   <= '0;
						crc_q   <= '1;
						err_q   <= 1'b0;
					end else begin
						state_q <= ST_DROP;           // bad SFD or no free slot
					end
				end
				ST_DATA: begin
					if (!rx_i.dv) begin
						state_q <= ST_HUNT;
					end else if (too_long) begin
						state_q <= ST_DROP;
					end else begin
						cnt_q <= cnt_q + plen_t'(1);
						crc_q <= next_crc32_d8(rx_i.data, crc_q);
						err_q <= err_q | rx_i.er;
					end
				end
				ST_DROP: begin
					if (!rx_i.dv)
						state_q <= ST_HUNT;           // wait out the rest of the run
				end
				default: state_q <= ST_HUNT;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/eth_mac.sv ====
`timescale 1ns/100ps
`default_nettype none

module eth_mac import eth_pkg::*; (
	input  wire            clock,
	input  wire            reset,
	input  wire            start_i,
	input  wire host_req_t req_i,
	output logic           done_o,
	output result_t        result_o,
	output gmii_tx_t       gmii_tx_o,
	input  wire gmii_rx_t  gmii_rx_i
);

	// ------------------------------
	// transmit ring wires
	// ------------------------------
	ring_wr_t   tx_wr;
	ring_stat_t tx_stat;
	logic       tx_full;
	plen_t      tx_rd_addr;
	byte_t      tx_rd_data;
	logic       tx_release;

	// ------------------------------
	// receive ring wires
	// ------------------------------
	ring_wr_t   rx_wr;
	ring_stat_t rx_stat;
	logic       rx_full;
	plen_t      rx_rd_addr;
	byte_t      rx_rd_data;
	logic       rx_release;

	packet_ring tx_ring (
		.clock,
		.reset,
		.wr_i      (tx_wr),
		.stat_o    (tx_stat),
		.full_o    (tx_full),
		.rd_addr_i (tx_rd_addr),
		.rd_data_o (tx_rd_data),
		.release_i (tx_release)
	);

	packet_ring rx_ring (
		.clock,
		.reset,
		.wr_i      (rx_wr),
		.stat_o    (rx_stat),
		.full_o    (rx_full),
		.rd_addr_i (rx_rd_addr),
		.rd_data_o (rx_rd_data),
		.release_i (rx_release)
	);

	host_port host (
		.clock,
		.reset,
		.start_i,
		.req_i,
		.done_o,
		.result_o,
		.tx_wr_o      (tx_wr),
		.tx_full_i    (tx_full),
		.rx_stat_i    (rx_stat),
		.rx_rd_addr_o (rx_rd_addr),
		.rx_rd_data_i (rx_rd_data),
		.rx_release_o (rx_release)
	);

	gmii_tx tx_mac (
		.clock,
		.reset,
		.stat_i    (tx_stat),
		.rd_addr_o (tx_rd_addr),
		.rd_data_i (tx_rd_data),
		.release_o (tx_release),
		.tx_o      (gmii_tx_o)
	);

	gmii_rx rx_mac (
		.clock,
		.reset,
		.rx_i   (gmii_rx_i),
		.wr_o   (rx_wr),
		.full_i (rx_full)
	);

endmodule

`default_nettype wire

// ==== test/tb_frames.svh ====
`ifndef TB_FRAMES_SVH
`define TB_FRAMES_SVH

typedef byte_t bytes_t[$];

// reflected CRC-32 as in IEEE 802.3, returned already complemented
function automatic logic [31:0] ref_crc(input bytes_t bytes);
	logic [31:0] crc;
	crc = 32'hFFFF_FFFF;
	foreach (bytes[i]) begin
		crc = crc ^ {24'h0, bytes[i]};
		for (int b = 0; b < 8; b++)
			crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
	end
	return ~crc;
endfunction

// preamble, SFD, payload, then FCS with the low byte first on the wire
function automatic bytes_t build_frame(input bytes_t payload);
	bytes_t      frame;
	logic [31:0] fcs;
	fcs = ref_crc(payload);
	for (int i = 0; i < int'(PREAMBLE_LEN); i++)
		frame.push_back(PREAMBLE_BYTE);
	frame.push_back(SFD_BYTE);
	foreach (payload[i])
		frame.push_back(payload[i]);
	frame.push_back(fcs[7:0]);
	frame.push_back(fcs[15:8]);
	frame.push_back(fcs[23:16]);
	frame.push_back(fcs[31:24]);
	return frame;
endfunction

function automatic bytes_t random_payload(input int len);
	bytes_t p;
	for (int i = 0; i < len; i++)
		p.push_back(byte_t'($urandom));
	return p;
endfunction

`endif

// ==== test/tb_eth_mac.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_eth_mac import eth_pkg::*; ();

	localparam int RESET_CYCLES    = 16;
	localparam int MAX_TX_LEN      = 120;   // longest random transmit payload
	localparam int SHORT_TX_LEN    = 16;    // short packets queue behind a long one
	localparam int MAX_RX_LEN      = 48;
	localparam int HOST_TIMEOUT    = 4;
	localparam int TX_DRAIN_LIMIT  = 3 * (MAX_TX_LEN + 40);
	localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + 32 + 4 * (3 * MAX_TX_LEN + 40)
		+ 13 * (3 * MAX_RX_LEN + 40));

	`include "tb_frames.svh"

	logic      clock = 1'b0;
	logic      reset;
	logic      start;
	host_req_t req;
	logic      done;
	result_t   result;
	gmii_tx_t  tx;
	gmii_rx_t  rx;

	bytes_t    cap_frame;        // last frame seen on the tx side
	bytes_t    exp_bytes;
	int        exp_lens[$];
	int        frames_seen    = 0;
	int        frames_checked = 0;

	eth_mac i_eth_mac (
		.clock,
		.reset,
		.start_i   (start),
		.req_i     (req),
		.done_o    (done),
		.result_o  (result),
		.gmii_tx_o (tx),
		.gmii_rx_i (rx)
	);

	always #5 clock = ~clock;

	// ------------------------------
	// failure and compare tasks
	// ------------------------------
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_result(input string name, input result_t got, input result_t exp);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_len(input string name, input plen_t got, input plen_t exp);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d",
				$time, name, got, exp));
	endtask

	// ------------------------------
	// host operations
	// ------------------------------
	task automatic host_op(input host_op_t op, input plen_t addr, input byte_t data,
			output result_t res);
		int waited;
		waited    = 0;
		start     = 1'b1;
		req.op    = op;
		req.addr  = addr;
		req.data  = data;
		@(posedge clock);
		#1;
		start = 1'b0;
		while (!done) begin
			if (waited == HOST_TIMEOUT)
				fail_run("host operation got no done pulse");
			waited++;
			@(posedge clock);
			#1;
		end
		res = result;
		@(posedge clock);   // no strobe while done is high
		#1;
	endtask

	task automatic expect_op(input host_op_t op, input plen_t addr, input byte_t data,
			input result_t exp, input string name);
		result_t got;
		host_op(op, addr, data, got);
		check_result(name, got, exp);
	endtask

	task automatic write_payload(input bytes_t payload);
		result_t got;
		foreach (payload[i])
			expect_op(OP_WRITE, plen_t'(i), payload[i], '0, "write result");
		host_op(OP_WRITE_LEN, '0, '0, got);
		check_len("write length", plen_t'(got), plen_t'(payload.size()));
	endtask

	task automatic commit_packet(input bytes_t payload);
		bytes_t frame;
		frame = build_frame(payload);
		foreach (frame[i])
			exp_bytes.push_back(frame[i]);
		exp_lens.push_back(frame.size());   // queued before the frame can start
		expect_op(OP_WRITE_NEXT, '0, '0, '0, "write next result");
	endtask

	task automatic read_packet(input bytes_t payload);
		result_t got;
		host_op(OP_READ_LEN, '0, '0, got);
		check_len("read length", plen_t'(got), plen_t'(payload.size()));
		foreach (payload[i]) begin
			host_op(OP_READ, plen_t'(i), '0, got);
			check_byte($sformatf("read byte %0d", i), byte_t'(got), payload[i]);
		end
		expect_op(OP_READ_NEXT, '0, '0, '0, "read next result");
	endtask

	task automatic wait_tx_drained();
		int waited;
		waited = 0;
		while (exp_lens.size() != 0) begin
			if (waited == TX_DRAIN_LIMIT)
				fail_run("committed packets did not come out on GMII in time");
			waited++;
			@(posedge clock);
		end
		@(posedge clock);
		#1;
	endtask

	// drives one byte per cycle and keeps rx_er low for a negative er_index
	task automatic drive_rx(input bytes_t frame, input int er_index);
		foreach (frame[i]) begin
			rx.dv   = 1'b1;
			rx.er   = (i == er_index);
			rx.data = frame[i];
			@(posedge clock);
			#1;
		end
		rx = '0;
		repeat (4) @(posedge clock);
		#1;
	endtask

	// ------------------------------
	// tx monitor and compare
	// ------------------------------
	initial begin : tx_monitor
		bytes_t cur;
		int     idle;
		idle = 0;
		wait (!reset);
		forever begin
			@(negedge clock);
			if (tx.en) begin
				if (cur.size() == 0 && frames_seen > 0 && idle < int'(IFG_LEN))
					fail_run($sformatf("gap of %0d idle cycles between frames is too short", idle));
				cur.push_back(tx.data);
				idle = 0;
			end else begin
				if (cur.size() != 0) begin
					cap_frame = cur;
					cur.delete();
					frames_seen++;
				end
				idle++;
			end
		end
	end

	initial begin : tx_compare
		int n;
		forever begin
			wait (frames_seen > frames_checked);
			if (exp_lens.size() == 0)
				fail_run("a frame came out on GMII with no packet committed");
			n = exp_lens.pop_front();
			check_len("tx frame length", plen_t'(cap_frame.size()), plen_t'(n));
			for (int i = 0; i < n; i++)
				check_byte($sformatf("tx frame %0d byte %0d", frames_checked, i),
					cap_frame[i], exp_bytes.pop_front());
			frames_checked++;
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		fail_run($sformatf("timeout, the run did not end within %0d cycles", WATCHDOG_CYCLES));
	end

	// ------------------------------
	// stimulus
	// ------------------------------
	initial begin : stimulus
		bytes_t payload;
		bytes_t frame;
		bytes_t stored;        // overflow payloads back to back
		int     stored_lens[$];
		int     n;
		reset = 1'b1;
		start = 1'b0;
		req   = '0;
		rx    = '0;
		void'($urandom(93));
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset = 1'b0;

		repeat (32) begin
			@(negedge clock);
			if (tx.en)
				fail_run("tx_en went high after reset with no packet committed");
		end
		@(posedge clock);
		#1;
		expect_op(OP_READ_LEN, '0, '0, '0, "read length after reset");
		expect_op(OP_READ_NEXT, '0, '0, 16'd1, "read next after reset");

		payload = random_payload($urandom_range(MAX_TX_LEN, 1));
		write_payload(payload);
		expect_op(OP_WRITE, MAX_LEN, 8'hA5, 16'd1, "write at MAX_LEN");
		commit_packet(payload);
		wait_tx_drained();

		// the short ones are committed while the long one is still on the wire
		for (int k = 0; k < 3; k++) begin   // order and gap
			if (k == 0)
				payload = random_payload(MAX_TX_LEN);
			else
				payload = random_payload($urandom_range(SHORT_TX_LEN, 1));
			write_payload(payload);
			commit_packet(payload);
		end
		wait_tx_drained();

		payload = random_payload($urandom_range(MAX_RX_LEN, 1));
		drive_rx(build_frame(payload), -1);
		expect_op(OP_READ, plen_t'(payload.size()), '0, '0, "read past length");
		read_packet(payload);
		expect_op(OP_READ_NEXT, '0, '0, 16'd1, "read next when empty");

		payload = random_payload(16);
		frame   = build_frame(payload);
		frame[frame.size() - 1] = frame[frame.size() - 1] ^ 8'h01;   // bad FCS
		drive_rx(frame, -1);
		expect_op(OP_READ_LEN, '0, '0, '0, "read length after bad FCS");
		drive_rx(build_frame(payload), int'(PREAMBLE_LEN) + 1);
		expect_op(OP_READ_LEN, '0, '0, '0, "read length after rx_er");
		frame    = build_frame(payload);
		frame[7] = 8'hD4;
		drive_rx(frame, -1);
		expect_op(OP_READ_LEN, '0, '0, '0, "read length after bad SFD");

		repeat (RING_DEPTH + 1) begin   // one more than the ring holds
			payload = random_payload($urandom_range(MAX_RX_LEN, 1));
			foreach (payload[i])
				stored.push_back(payload[i]);
			stored_lens.push_back(payload.size());
			drive_rx(build_frame(payload), -1);
		end
		repeat (RING_DEPTH) begin
			payload.delete();
			n = stored_lens.pop_front();
			repeat (n) payload.push_back(stored.pop_front());
			read_packet(payload);
		end
		expect_op(OP_READ_NEXT, '0, '0, 16'd1, "read next after overflow");

		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+test
hdl/eth_pkg.sv
hdl/packet_ring.sv
hdl/host_port.sv
hdl/gmii_tx.sv
hdl/gmii_rx.sv
hdl/eth_mac.sv
test/tb_eth_mac.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_eth_mac -f all.f

# the pass line has to show up, a $fatal or a missing line fails the grep
./obj_dir/Vtb_eth_mac | tee /dev/stderr | grep -Fx "Finished with no errors"
